// File: design/lwe_pkg.sv
`default_nettype none

package lwe_pkg;

   // datapath widths
   localparam int lane_w = 16;
   localparam int n_lanes = 2;
   localparam int word_w = lane_w * n_lanes;
   localparam int bytes_per_word = word_w / 8;
   localparam int byte_idx_w = $clog2(bytes_per_word);

   localparam int msg_shift = 6;  // message bit position inside a lane

   // flow control
   localparam int row_slots = 4;  // fifo depth and upstream row credits
   localparam int out_credits_init = 2;  // word credits held after reset
   localparam int credit_w = $clog2(out_credits_init + row_slots + 1);
   localparam int fifo_ptr_w = $clog2(row_slots);
   localparam int fifo_cnt_w = $clog2(row_slots + 1);

   // ternary secret, two's complement style
   typedef logic [1:0] secret_t;

   localparam secret_t sec_zero = 2'b00;
   localparam secret_t sec_plus = 2'b01;
   localparam secret_t sec_minus = 2'b11;
   localparam secret_t sec_bad = 2'b10;  // never legal on the bus

   typedef secret_t [n_lanes-1:0] secret_pair_t;  // one secret per lane

   // lane view for the arithmetic, byte view for the output stream
   typedef union packed {
      logic [n_lanes-1:0][lane_w-1:0] lane;
      logic [bytes_per_word-1:0][7:0] bytes;
   } lane_word_t;

endpackage

`default_nettype wire

// File: design/term_if.sv
`timescale 1ns/1ps
`default_nettype none

// one term per cycle, row data rides along with last
interface term_if import lwe_pkg::*; ();
   logic valid;
   lane_word_t a_word;  // coefficient lanes
   secret_pair_t s;
   logic last;  // closes the row
   lane_word_t b_word;  // only meaningful with last
   logic [n_lanes-1:0] msg;  // one message bit per lane, with last

   modport source (output valid, a_word, s, last, b_word, msg);
   modport sink (input valid, a_word, s, last, b_word, msg);
endinterface

`default_nettype wire

// File: design/inner_product.sv
`timescale 1ns/1ps
`default_nettype none

module inner_product import lwe_pkg::*; (
   input wire clk_100mhz,
   input wire sys_rst,
   term_if.sink term,
   output logic sum_valid,
   output lane_word_t sum_word
);

   lane_word_t prod_d;
   lane_word_t prod_q;
   logic prod_valid;
   logic prod_last;
   lane_word_t acc;
   lane_word_t acc_next;

   // ternary multiply is just a select
   always_comb begin
      for (int i = 0; i < n_lanes; i++) begin
         case (term.s[i])
            sec_plus: prod_d.lane[i] = term.a_word.lane[i];
            sec_minus: prod_d.lane[i] = -term.a_word.lane[i];  // wraps mod 2^16
            sec_zero: prod_d.lane[i] = '0;
            default: prod_d.lane[i] = '0;
         endcase
      end
   end

   // stage 1, registered products
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         prod_valid <= 1'b0;
         prod_last <= 1'b0;
      end else begin
         prod_valid <= term.valid;
         prod_last <= term.valid && term.last;
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (term.valid) prod_q <= prod_d;
   end

   always_comb begin
      for (int i = 0; i < n_lanes; i++) begin
         acc_next.lane[i] = acc.lane[i] + prod_q.lane[i];
      end
   end

   // stage 2, accumulate; the row-end sum leaves and acc restarts at zero
   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         acc <= '0;
         sum_valid <= 1'b0;
      end else begin
         sum_valid <= prod_last;
         if (prod_valid) begin
            acc <= prod_last ? lane_word_t'('0) : acc_next;
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (prod_last) sum_word <= acc_next;
   end

   // upstream must never drive the unused secret code
   for (genvar g = 0; g < n_lanes; g++) begin : g_secret_chk
      a_secret_legal: assert property (
         @(posedge clk_100mhz) disable iff (sys_rst)
         term.valid |-> term.s[g] != sec_bad
      ) else $error("illegal secret code on lane %0d", g);
   end

endmodule

`default_nettype wire

// File: design/message_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module message_encoder import lwe_pkg::*; (
   input wire clk_100mhz,
   input wire sys_rst,
   term_if.sink term,
   output logic bias_valid,
   output lane_word_t bias_word
);

   lane_word_t bias_d;
   lane_word_t bias_q;
   logic bias_q_valid;

   // b + (m << 6), per lane
   always_comb begin
      for (int i = 0; i < n_lanes; i++) begin
         bias_d.lane[i] = term.b_word.lane[i] + (lane_w'(term.msg[i]) << msg_shift);
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         bias_q_valid <= 1'b0;
         bias_valid <= 1'b0;
      end else begin
         bias_q_valid <= term.valid && term.last;
         bias_valid <= bias_q_valid;  // second stage matches the mac latency
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (term.valid && term.last) bias_q <= bias_d;
      if (bias_q_valid) bias_word <= bias_q;
   end

endmodule

`default_nettype wire

// File: design/cipher_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module cipher_combiner import lwe_pkg::*; (
   input wire clk_100mhz,
   input wire sys_rst,
   input wire sum_valid,
   input wire lane_word_t sum_word,
   input wire bias_valid,
   input wire lane_word_t bias_word,
   input wire pop,
   output logic not_empty,
   output lane_word_t head_word
);

   lane_word_t mem [row_slots];
   lane_word_t cipher;
   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic [fifo_cnt_w-1:0] count;
   logic push;
   logic full;

   function automatic logic [fifo_ptr_w-1:0] ptr_inc(input logic [fifo_ptr_w-1:0] ptr);
      if (ptr == fifo_ptr_w'(row_slots - 1)) begin
         return '0;
      end
      return ptr + fifo_ptr_w'(1);
   endfunction

   // ciphertext lane = <a,s> + b + m*64
   always_comb begin
      for (int i = 0; i < n_lanes; i++) begin
         cipher.lane[i] = sum_word.lane[i] + bias_word.lane[i];
      end
   end

   assign push = sum_valid && bias_valid;
   assign full = (count == fifo_cnt_w'(row_slots));
   assign not_empty = (count != '0);
   assign head_word = mem[rd_ptr];  // show-ahead read

   always_ff @(posedge clk_100mhz) begin
      if (push) mem[wr_ptr] <= cipher;
   end

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + fifo_cnt_w'(push) - fifo_cnt_w'(pop);
      end
   end

   // both partial results come from the same last term
   a_partials_aligned: assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      sum_valid == bias_valid
   ) else $error("sum and bias out of step");

   // row credits bound the rows in flight to the fifo depth
   a_no_overflow: assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      push |-> !full
   ) else $error("push into full ciphertext fifo");

endmodule

`default_nettype wire

// File: design/byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_serializer import lwe_pkg::*; (
   input wire clk_100mhz,
   input wire sys_rst,
   input wire not_empty,
   input wire lane_word_t head_word,
   input wire out_credit,
   output logic pop,
   output logic in_credit,
   output logic out_valid,
   output logic [7:0] out_byte
);

   logic [credit_w-1:0] credits;  // word credits from the sink
   logic [byte_idx_w-1:0] idx;  // zero when idle or on the last byte
   lane_word_t word_q;

   // idx is zero while idle and during the last byte, so words go back to back
   assign pop = not_empty && (credits != '0) && (idx == '0);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         credits <= credit_w'(out_credits_init);
         idx <= '0;
         out_valid <= 1'b0;
         out_byte <= '0;
         in_credit <= 1'b0;
      end else begin
         credits <= credits + credit_w'(out_credit) - credit_w'(pop);
         in_credit <= pop;  // freed fifo slot goes back as a row credit
         if (pop) begin
            out_valid <= 1'b1;
            out_byte <= head_word.bytes[0];  // lane 0 low byte first
            idx <= byte_idx_w'(1);
         end else if (idx != '0) begin
            out_byte <= word_q.bytes[idx];
            idx <= (idx == byte_idx_w'(bytes_per_word - 1)) ? '0 : idx + byte_idx_w'(1);
         end else begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (pop) word_q <= head_word;
   end

   // sink may not grant more than it can hold plus the rows in flight
   a_credit_bound: assert property (
      @(posedge clk_100mhz) disable iff (sys_rst)
      credits <= credit_w'(out_credits_init + row_slots)
   ) else $error("word credit count above bound: %0d", credits);

endmodule

`default_nettype wire

// File: design/lwe_enc_top.sv
`timescale 1ns/1ps
`default_nettype none

module lwe_enc_top import lwe_pkg::*; (
   input wire clk_100mhz,
   input wire sys_rst,
   input wire in_valid,
   input wire [word_w-1:0] in_a_word,
   input wire secret_pair_t in_s,
   input wire in_last,
   input wire [word_w-1:0] in_b_word,
   input wire [n_lanes-1:0] in_msg,
   output logic in_credit,
   output logic out_valid,
   output logic [7:0] out_byte,
   input wire out_credit
);

   logic sum_valid;
   lane_word_t sum_word;
   logic bias_valid;
   lane_word_t bias_word;
   logic not_empty;
   lane_word_t head_word;
   logic pop;

   term_if term_bus ();

   // no ready, every valid term is taken
   assign term_bus.valid = in_valid;
   assign term_bus.a_word = in_a_word;
   assign term_bus.s = in_s;
   assign term_bus.last = in_last;
   assign term_bus.b_word = in_b_word;
   assign term_bus.msg = in_msg;

   inner_product inner_product_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .term(term_bus.sink),
      .sum_valid(sum_valid),
      .sum_word(sum_word)
   );

   message_encoder message_encoder_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .term(term_bus.sink),
      .bias_valid(bias_valid),
      .bias_word(bias_word)
   );

   cipher_combiner cipher_combiner_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .sum_valid(sum_valid),
      .sum_word(sum_word),
      .bias_valid(bias_valid),
      .bias_word(bias_word),
      .pop(pop),
      .not_empty(not_empty),
      .head_word(head_word)
   );

   byte_serializer byte_serializer_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .not_empty(not_empty),
      .head_word(head_word),
      .out_credit(out_credit),
      .pop(pop),
      .in_credit(in_credit),
      .out_valid(out_valid),
      .out_byte(out_byte)
   );

endmodule

`default_nettype wire

// File: sim/lwe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lwe_checker import lwe_pkg::*; #(
   parameter int n_rows = 10,
   parameter int wait_limit = 500
) (
   input wire clk_100mhz,
   input wire sys_rst,
   input wire in_credit,
   input wire out_valid,
   input wire [7:0] out_byte,
   input wire out_credit,
   input var lane_word_t exp_words [n_rows],
   output logic done,
   output int value_errors,
   output int other_errors
);

   int byte_errs = 0;
   int mon_errs = 0;
   int seq_fails = 0;
   int grants = 0;  // out_credit pulses since reset
   int credit_pulses = 0;
   int valid_cycles = 0;
   logic rst_p = 1'b1;
   logic rst_pp = 1'b1;

   assign value_errors = byte_errs + mon_errs;
   assign other_errors = seq_fails;

   // reset and credits sampled on the rising edge while the driver holds them
   always @(posedge clk_100mhz) begin
      rst_p <= sys_rst;
      rst_pp <= rst_p;
      if (sys_rst) grants <= 0;
      else if (out_credit) grants <= grants + 1;
   end

   always @(negedge clk_100mhz) begin
      if (rst_p || rst_pp) begin  // reset and the cycle after
         if (out_valid !== 1'b0) begin
            $display("ERR %0t out_valid exp 0 act %b", $time, out_valid);
            mon_errs++;
         end
         if (in_credit !== 1'b0) begin
            $display("ERR %0t in_credit exp 0 act %b", $time, in_credit);
            mon_errs++;
         end
      end else begin
         if (in_credit) credit_pulses <= credit_pulses + 1;
         if (out_valid) valid_cycles <= valid_cycles + 1;
      end
   end

   initial begin : byte_check
      int cnt;
      lane_word_t exp_word;
      done = 1'b0;
      cnt = 0;
      do begin
         @(negedge clk_100mhz);
         cnt++;
      end while (rst_pp !== 1'b0 && cnt < wait_limit);
      if (rst_pp !== 1'b0) begin
         $display("reset was never released");
         seq_fails++;
      end
      for (int w = 0; w < n_rows && seq_fails == 0; w++) begin
         exp_word = exp_words[w];
         cnt = 0;
         do begin
            @(negedge clk_100mhz);
            cnt++;
         end while (!out_valid && cnt < wait_limit);
         if (!out_valid) begin
            $display("timeout: word %0d never showed up on the byte stream", w);
            seq_fails++;
         end else begin
            if (w + 1 > out_credits_init + grants) begin
               $display("word %0d came out without a word credit", w);
               seq_fails++;
            end
            for (int b = 0; b < bytes_per_word; b++) begin
               if (b != 0) @(negedge clk_100mhz);
               if (out_valid !== 1'b1) begin
                  $display("ERR %0t out_valid exp 1 act %b", $time, out_valid);
                  byte_errs++;
               end
               if (out_byte !== exp_word.bytes[b]) begin
                  $display("ERR %0t out_byte exp %02h act %02h", $time,
                           exp_word.bytes[b], out_byte);
                  byte_errs++;
               end
            end
         end
      end
      repeat (40) @(negedge clk_100mhz);  // idle window for stray bytes
      if (valid_cycles != n_rows * bytes_per_word) begin
         $display("ERR %0t out_valid cycles exp %0d act %0d", $time,
                  n_rows * bytes_per_word, valid_cycles);
         byte_errs++;
      end
      if (credit_pulses != n_rows) begin
         $display("ERR %0t in_credit pulses exp %0d act %0d", $time, n_rows, credit_pulses);
         byte_errs++;
      end
      done = 1'b1;
   end

endmodule

`default_nettype wire

// File: sim/tb_lwe_enc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lwe_enc import lwe_pkg::*; ();

   localparam int n_rows = 10;
   localparam int max_terms = 4;
   localparam int wait_limit = 500;
   localparam logic [31:0] lcg_seed = 32'h9b7d;

   logic clk_100mhz = 1'b0;
   logic sys_rst;
   logic in_valid;
   logic [31:0] in_a_word;
   secret_pair_t in_s;
   logic in_last;
   logic [31:0] in_b_word;
   logic [1:0] in_msg;
   logic in_credit;
   logic out_valid;
   logic [7:0] out_byte;
   logic out_credit;

   logic checker_done;
   int value_errors;
   int other_errors;

   // secrets per term, lane 0 then lane 1: + plus one, - minus one, 0 zero
   string sec_tab [n_rows] = '{"++", "++", "++", "-++-", "0---+0",
                               "++++++++", "--------", "00-+", "+--+0+", "-0+-00-+"};
   logic [1:0] msg_tab [n_rows] = '{2'b01, 2'b10, 2'b11, 2'b00, 2'b01,
                                    2'b11, 2'b10, 2'b01, 2'b00, 2'b11};
   lane_word_t a_tab [n_rows][max_terms];
   lane_word_t b_tab [n_rows];
   lane_word_t exp_tab [n_rows];  // expected ciphertext per row

   logic [31:0] lcg_state;
   int returned_credits;  // in_credit pulses seen by the stimulus
   int tb_fails;

   lwe_enc_top lwe_enc_top_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .in_valid(in_valid),
      .in_a_word(in_a_word),
      .in_s(in_s),
      .in_last(in_last),
      .in_b_word(in_b_word),
      .in_msg(in_msg),
      .in_credit(in_credit),
      .out_valid(out_valid),
      .out_byte(out_byte),
      .out_credit(out_credit)
   );

   lwe_checker #(.n_rows(n_rows), .wait_limit(wait_limit)) lwe_checker_inst (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .in_credit(in_credit),
      .out_valid(out_valid),
      .out_byte(out_byte),
      .out_credit(out_credit),
      .exp_words(exp_tab),
      .done(checker_done),
      .value_errors(value_errors),
      .other_errors(other_errors)
   );

   initial begin
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int secret_value(input byte c);
      if (c == "+") return 1;
      if (c == "-") return -1;
      return 0;
   endfunction

   function automatic secret_t secret_code(input int v);
      if (v == 1) return 2'b01;
      if (v == -1) return 2'b11;
      return 2'b00;
   endfunction

   // coefficients and b from the lcg, expected words by the wrap rule
   task automatic build_table();
      int acc;
      int n;
      for (int r = 0; r < n_rows; r++) begin
         n = sec_tab[r].len() / 2;
         lcg_state = lcg_next(lcg_state);
         b_tab[r] = lcg_state;
         for (int t = 0; t < max_terms; t++) begin
            lcg_state = lcg_next(lcg_state);
            // large coefficients on multi-term rows so the sums wrap
            a_tab[r][t] = (n > 1) ? (lcg_state | 32'hc000c000) : lcg_state;
         end
         for (int l = 0; l < n_lanes; l++) begin
            acc = int'(b_tab[r].lane[l]) + (int'(msg_tab[r][l]) << msg_shift);
            for (int t = 0; t < n; t++) begin
               acc += int'(a_tab[r][t].lane[l]) * secret_value(sec_tab[r][2*t+l]);
            end
            exp_tab[r].lane[l] = acc[15:0];
         end
      end
   endtask

   // one stimulus cycle, row credits counted where in_credit is stable
   task automatic tick();
      @(negedge clk_100mhz);
      if (!sys_rst && in_credit) returned_credits++;
   endtask

   task automatic send_row(input int r, output bit ok);
      int cnt;
      int n;
      n = sec_tab[r].len() / 2;
      cnt = 0;
      while (r - returned_credits >= row_slots && cnt < wait_limit) begin
         tick();
         cnt++;
      end
      ok = (r - returned_credits < row_slots);
      if (!ok) $display("timeout: no row credit came back for row %0d", r);
      for (int t = 0; t < n && ok; t++) begin
         in_valid = 1'b1;
         in_a_word = a_tab[r][t];
         in_s[0] = secret_code(secret_value(sec_tab[r][2*t]));
         in_s[1] = secret_code(secret_value(sec_tab[r][2*t+1]));
         in_last = (t == n - 1);
         in_b_word = b_tab[r];
         in_msg = msg_tab[r];
         tick();
      end
      in_valid = 1'b0;
      in_last = 1'b0;
   endtask

   // word credit driver, holds back credits first so the fifo fills
   initial begin : credit_driver
      int gap;
      int cnt;
      out_credit = 1'b0;
      cnt = 0;
      @(posedge clk_100mhz);
      while (sys_rst !== 1'b0 && cnt < wait_limit) begin
         @(posedge clk_100mhz);
         cnt++;
      end
      @(negedge clk_100mhz);
      repeat (60) @(negedge clk_100mhz);
      for (int p = 0; p < n_rows - out_credits_init; p++) begin
         lcg_state = lcg_next(lcg_state);
         gap = 6 + int'(lcg_state[20:16]);
         repeat (gap) @(negedge clk_100mhz);
         out_credit = 1'b1;
         @(negedge clk_100mhz);
         out_credit = 1'b0;
      end
   end

   initial begin : main
      bit ok;
      int drain;
      sys_rst = 1'b1;
      in_valid = 1'b0;
      in_a_word = '0;
      in_s = '0;
      in_last = 1'b0;
      in_b_word = '0;
      in_msg = '0;
      lcg_state = lcg_seed;
      returned_credits = 0;
      tb_fails = 0;
      build_table();
      repeat (16) tick();
      sys_rst = 1'b0;

      ok = 1'b1;
      for (int r = 0; r < n_rows && ok; r++) send_row(r, ok);

      drain = 0;
      while (ok && !checker_done && drain < n_rows * wait_limit + 100) begin
         tick();
         drain++;
      end
      if (ok && !checker_done) begin
         $display("timeout: output checker never finished");
         ok = 1'b0;
      end
      if (!ok) tb_fails++;

      $display("summary: %0d value errors, %0d other failures",
               value_errors, other_errors + tb_fails);
      if (value_errors == 0 && other_errors + tb_fails == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
design/lwe_pkg.sv
design/term_if.sv
design/inner_product.sv
design/message_encoder.sv
design/cipher_combiner.sv
design/byte_serializer.sv
design/lwe_enc_top.sv
sim/lwe_checker.sv
sim/tb_lwe_enc.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_lwe_enc
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)
